// File: sched_pkg.sv
// Shared widths, the queue item and AXI4-Lite channel structs,
// register offsets and response codes of the queue scheduler
`default_nettype none

package sched_pkg;

  // Datapath widths
  localparam int DATA_W  = 32;
  localparam int MAX_Q   = 8;
  localparam int QID_W   = 3;
  // AXI4-Lite widths
  localparam int AXIL_AW = 8;
  localparam int AXIL_DW = 32;

  // Egress item, tag on top
  typedef struct packed {
    logic [QID_W-1:0]  qid;
    logic [DATA_W-1:0] data;
  } sched_item_t;

  // Master-driven AXI4-Lite signals
  typedef struct packed {
    logic                 awvalid;
    logic [AXIL_AW-1:0]   awaddr;
    logic                 wvalid;
    logic [AXIL_DW-1:0]   wdata;
    logic [AXIL_DW/8-1:0] wstrb;
    logic                 bready;
    logic                 arvalid;
    logic [AXIL_AW-1:0]   araddr;
    logic                 rready;
  } axil_req_t;

  // Slave-driven AXI4-Lite signals
  typedef struct packed {
    logic               awready;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               arready;
    logic               rvalid;
    logic [AXIL_DW-1:0] rdata;
    logic [1:0]         rresp;
  } axil_rsp_t;

  // Register map, counters at a 4 byte stride
  localparam logic [AXIL_AW-1:0] REG_CTRL      = 8'h00;
  localparam logic [AXIL_AW-1:0] REG_STATUS    = 8'h04;
  localparam logic [AXIL_AW-1:0] REG_GCNT_BASE = 8'h10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: rr_arbiter.sv
// Round-robin arbiter core
// Last-granted pointer, wrapping search above it, pointer update on strobe
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
  parameter int NUM_REQS = 4,
  parameter int IDX_W    = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic [NUM_REQS-1:0] reqs,
  input  wire logic                update,
  output logic                     winner_v,
  output logic [IDX_W-1:0]         winner
);

  // Index of the most recently granted request
  logic [IDX_W-1:0] last_ptr;

  // --------------------------------------------------------------------------
  // Winner search
  // --------------------------------------------------------------------------
  // Start one above the pointer, wrap at NUM_REQS
  // First hit wins, so the last grant sits at the bottom
  always_comb begin
    int unsigned idx;
    winner_v = 1'b0;
    winner   = '0;
    for (int i = 1; i <= NUM_REQS; i++) begin
      idx = int'(last_ptr) + i;
      if (idx >= NUM_REQS) begin
        idx = idx - NUM_REQS;
      end
      if (!winner_v && reqs[idx]) begin
        winner_v = 1'b1;
        winner   = IDX_W'(idx);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Pointer update
  // --------------------------------------------------------------------------
  // Reset value puts request 0 at top priority
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_ptr <= IDX_W'(NUM_REQS - 1);
    end else if (update && winner_v) begin
      // Current winner drops to lowest priority
      last_ptr <= winner;
    end
  end

endmodule

`default_nettype wire

// File: fair_arb.sv
// Fair arbiter
// Wraps the round-robin core and decodes its winner index to a one-hot grant
`timescale 1ns/10ps
`default_nettype none

module fair_arb #(
  parameter int LINES = 4
) (
  input  wire logic             clk,
  input  wire logic             arst_n,
  input  wire logic [LINES-1:0] req,
  input  wire logic             update,
  output logic      [LINES-1:0] gnt
);

  localparam int LOG2LINES = (LINES > 1) ? $clog2(LINES) : 1;

  logic                 winner_v;
  logic [LOG2LINES-1:0] winner;

  rr_arbiter #(
    .NUM_REQS (LINES),
    .IDX_W    (LOG2LINES)
  ) rr_arb_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .reqs     (req),
    .update   (update),
    .winner_v (winner_v),
    .winner   (winner)
  );

  generate
    if (LINES == 1) begin : g_one
      // Single line, the valid flag is the grant
      assign gnt = winner_v;
    end else begin : g_multi
      // Binary to one-hot, zero when nothing wins
      assign gnt = winner_v ? (LINES'(1) << winner) : '0;
    end
  endgenerate

  // Exactly one grant whenever any line requests
  a_gnt_onehot : assert property (@(posedge clk) disable iff (!arst_n)
    (|req) |-> $onehot(gnt));

  // Never grant a line that is not requesting
  a_gnt_in_req : assert property (@(posedge clk) disable iff (!arst_n) (gnt & ~req) == '0);

endmodule

`default_nettype wire

// File: ingress_fifo.sv
// Single-clock ingress FIFO for one queue
// Circular buffer, registered pointers and count, head shown while not empty
`timescale 1ns/10ps
`default_nettype none

module ingress_fifo import sched_pkg::*; #(
  parameter int DEPTH = 8,
  parameter int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  parameter int CNT_W = $clog2(DEPTH + 1)
) (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              push_valid,
  input  wire logic [DATA_W-1:0] push_data,
  output logic                   push_ready,
  input  wire logic              pop,
  output logic      [DATA_W-1:0] head_data,
  output logic                   not_empty,
  output logic      [CNT_W-1:0]  level
);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              wr_en;

  // Flags straight from the count
  assign push_ready = (count != CNT_W'(DEPTH));
  assign not_empty  = (count != '0);
  assign level      = count;
  assign head_data  = mem[rd_ptr];
  assign wr_en      = push_valid && push_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(pop);
    end
  end

  // Dispatcher pops only a visible entry
  a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n) pop |-> not_empty);

  // Count never runs past the buffer
  a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n) count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: egress_dispatch.sv
// Egress dispatch
// Load condition, tagged head mux, egress register with back-pressure hold,
// pop, arbiter update and grant counter pulses
`timescale 1ns/10ps
`default_nettype none

module egress_dispatch import sched_pkg::*; #(
  parameter int NUM_Q = 4
) (
  input  wire logic                          clk,
  input  wire logic                          arst_n,
  input  wire logic [NUM_Q-1:0]              gnt,
  input  wire logic [NUM_Q-1:0][DATA_W-1:0]  head_data,
  input  wire logic                          out_ready,
  output sched_item_t                        out_item,
  output logic                               out_valid,
  output logic      [NUM_Q-1:0]              pop,
  output logic                               arb_update,
  output logic      [NUM_Q-1:0]              grant_pulse
);

  logic        load;
  sched_item_t sel_item;

  // --------------------------------------------------------------------------
  // Load condition
  // --------------------------------------------------------------------------
  // Register free or draining this cycle, and someone granted
  assign load = (|gnt) && (!out_valid || out_ready);

  // All side effects of a load come from the same strobe
  assign pop         = load ? gnt : '0;
  assign grant_pulse = load ? gnt : '0;
  assign arb_update  = load;

  // --------------------------------------------------------------------------
  // Tagged head mux
  // --------------------------------------------------------------------------
  // Grant is one-hot so at most one branch hits
  always_comb begin
    sel_item = '0;
    for (int k = 0; k < NUM_Q; k++) begin
      if (gnt[k]) begin
        sel_item.qid  = QID_W'(k);
        sel_item.data = head_data[k];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Egress register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // Transfer done, nothing to refill
      out_valid <= 1'b0;
    end
  end

  // Payload only, qualified by out_valid
  always_ff @(posedge clk) begin
    if (load) begin
      out_item <= sel_item;
    end
  end

  // Stalled item stays put and stays valid
  a_hold_stalled : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_item));

endmodule

`default_nettype wire

// File: sched_csr.sv
// AXI4-Lite register block of the scheduler
// Write and read channel FSMs, queue enable mask, per-queue grant counters,
// non-empty status readback
`timescale 1ns/10ps
`default_nettype none

module sched_csr import sched_pkg::*; #(
  parameter int NUM_Q = 4
) (
  input  wire logic             clk,
  input  wire logic             arst_n,
  input  wire axil_req_t        axil_req,
  output axil_rsp_t             axil_rsp,
  input  wire logic [NUM_Q-1:0] not_empty,
  input  wire logic [NUM_Q-1:0] grant_pulse,
  output logic      [NUM_Q-1:0] ctrl_enable
);

  // Write channel
  logic                     wr_rdy;
  logic                     wr_fire;
  logic                     bvalid_q;
  logic [1:0]               bresp_q;
  logic                     wr_err;
  int                       wr_gcnt_idx;
  logic [AXIL_DW-1:0]       ctrl_merged;
  logic [NUM_Q-1:0]         gcnt_clr;
  // Read channel
  logic                     rd_rdy;
  logic                     rd_fire;
  logic                     rvalid_q;
  logic [1:0]               rresp_q;
  logic [AXIL_DW-1:0]       rdata_q;
  logic                     rd_err;
  logic [AXIL_DW-1:0]       rd_data;
  int                       rd_gcnt_idx;
  // Grant counters
  logic [NUM_Q-1:0][31:0]   gcnt;

  // Counter index for a word-aligned counter offset, else -1
  function automatic int gcnt_index(input logic [AXIL_AW-1:0] addr);
    int idx;
    idx = -1;
    if (addr[1:0] == 2'b00 && addr >= REG_GCNT_BASE) begin
      if (int'(addr - REG_GCNT_BASE) < 4 * NUM_Q) begin
        idx = int'((addr - REG_GCNT_BASE) >> 2);
      end
    end
    return idx;
  endfunction

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------
  // One write in flight, both ready lines pulse together
  assign wr_fire = wr_rdy && axil_req.awvalid && axil_req.wvalid;

  always_comb begin
    wr_gcnt_idx = gcnt_index(axil_req.awaddr);
    // STATUS is read-only, so only CTRL and counters decode
    wr_err      = !(axil_req.awaddr == REG_CTRL || wr_gcnt_idx >= 0);
    // Byte strobes applied over the current mask
    ctrl_merged = AXIL_DW'(ctrl_enable);
    for (int b = 0; b < AXIL_DW / 8; b++) begin
      if (axil_req.wstrb[b]) begin
        ctrl_merged[8*b +: 8] = axil_req.wdata[8*b +: 8];
      end
    end
    for (int k = 0; k < NUM_Q; k++) begin
      gcnt_clr[k] = wr_fire && (wr_gcnt_idx == k);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_rdy      <= 1'b0;
      bvalid_q    <= 1'b0;
      ctrl_enable <= '1;
    end else begin
      wr_rdy <= axil_req.awvalid && axil_req.wvalid && !wr_rdy && !bvalid_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (wr_fire && axil_req.awaddr == REG_CTRL) begin
        ctrl_enable <= ctrl_merged[NUM_Q-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Clear beats a same-cycle increment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gcnt <= '0;
    end else begin
      for (int k = 0; k < NUM_Q; k++) begin
        if (gcnt_clr[k]) begin
          gcnt[k] <= '0;
        end else if (grant_pulse[k]) begin
          gcnt[k] <= gcnt[k] + 32'd1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  assign rd_fire = rd_rdy && axil_req.arvalid;

  always_comb begin
    rd_gcnt_idx = gcnt_index(axil_req.araddr);
    rd_err      = 1'b0;
    rd_data     = '0;
    if (axil_req.araddr == REG_CTRL) begin
      rd_data = AXIL_DW'(ctrl_enable);
    end else if (axil_req.araddr == REG_STATUS) begin
      rd_data = AXIL_DW'(not_empty);
    end else if (rd_gcnt_idx >= 0) begin
      rd_data = gcnt[rd_gcnt_idx];
    end else begin
      rd_err = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_rdy   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rd_rdy <= axil_req.arvalid && !rd_rdy && !rvalid_q;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Response side of the bus
  assign axil_rsp.awready = wr_rdy;
  assign axil_rsp.wready  = wr_rdy;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.bresp   = bresp_q;
  assign axil_rsp.arready = rd_rdy;
  assign axil_rsp.rvalid  = rvalid_q;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = rresp_q;

  // Responses wait for the master
  a_b_hold : assert property (@(posedge clk) disable iff (!arst_n)
    bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q));
  a_r_hold : assert property (@(posedge clk) disable iff (!arst_n)
    rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));

endmodule

`default_nettype wire

// File: qsched_top.sv
// Ingress queue scheduler top level
// Per-queue FIFOs, fair arbiter, egress dispatch and AXI4-Lite register block
`timescale 1ns/10ps
`default_nettype none

module qsched_top import sched_pkg::*; #(
  parameter int NUM_Q      = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic [NUM_Q-1:0]             push_valid,
  input  wire logic [NUM_Q-1:0][DATA_W-1:0] push_data,
  output logic      [NUM_Q-1:0]             push_ready,
  output sched_item_t                       out_item,
  output logic                              out_valid,
  input  wire logic                         out_ready,
  input  wire axil_req_t                    axil_req,
  output axil_rsp_t                         axil_rsp
);

  // Tag field must hold every queue number
  if (NUM_Q > MAX_Q || NUM_Q < 1) begin : g_bad_num_q
    $error("NUM_Q out of range");
  end

  logic [NUM_Q-1:0]             not_empty;
  logic [NUM_Q-1:0][DATA_W-1:0] head_data;
  logic [NUM_Q-1:0]             pop;
  logic [NUM_Q-1:0]             ctrl_enable;
  logic [NUM_Q-1:0]             eligible;
  logic [NUM_Q-1:0]             gnt;
  logic [NUM_Q-1:0]             grant_pulse;
  logic                         arb_update;

  // --------------------------------------------------------------------------
  // Per-queue ingress FIFOs
  // --------------------------------------------------------------------------
  for (genvar k = 0; k < NUM_Q; k++) begin : g_fifo
    ingress_fifo #(
      .DEPTH      (FIFO_DEPTH)
    ) fifo_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .push_valid (push_valid[k]),
      .push_data  (push_data[k]),
      .push_ready (push_ready[k]),
      .pop        (pop[k]),
      .head_data  (head_data[k]),
      .not_empty  (not_empty[k]),
      .level      ()
    );
  end

  // Disabled queues keep their entries but do not compete
  assign eligible = not_empty & ctrl_enable;

  fair_arb #(
    .LINES  (NUM_Q)
  ) arb_i (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (eligible),
    .update (arb_update),
    .gnt    (gnt)
  );

  egress_dispatch #(
    .NUM_Q       (NUM_Q)
  ) dispatch_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .gnt         (gnt),
    .head_data   (head_data),
    .out_ready   (out_ready),
    .out_item    (out_item),
    .out_valid   (out_valid),
    .pop         (pop),
    .arb_update  (arb_update),
    .grant_pulse (grant_pulse)
  );

  sched_csr #(
    .NUM_Q       (NUM_Q)
  ) csr_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .not_empty   (not_empty),
    .grant_pulse (grant_pulse),
    .ctrl_enable (ctrl_enable)
  );

endmodule

`default_nettype wire

// File: tb_qsched.sv
// Testbench for the queue scheduler
// Clock and reset, xorshift stimulus, reference model with comparator,
// AXI4-Lite bus tasks and a cycle watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_qsched import sched_pkg::*; ();

  localparam int NUM_Q       = 4;
  localparam int FIFO_DEPTH  = 8;
  // Cycles with pushes enabled, summed over all phases, rounded up
  localparam int PUSH_CYCLES = 1000;
  localparam int TIMEOUT     = 4 * PUSH_CYCLES * NUM_Q + 2000;

  logic                         clk;
  logic                         arst_n;
  logic [NUM_Q-1:0]             push_valid;
  logic [NUM_Q-1:0][DATA_W-1:0] push_data;
  logic [NUM_Q-1:0]             push_ready;
  sched_item_t                  out_item;
  logic                         out_valid;
  logic                         out_ready;
  axil_req_t                    axil_req;
  axil_rsp_t                    axil_rsp;

  // Stimulus modes, 0 off, 1 always, 2 random
  int               push_mode  = 0;
  int               ready_mode = 0;
  logic [31:0]      rng        = 32'h03529eb0;
  // Reference model state
  logic [DATA_W-1:0] mq [NUM_Q][$];
  int               ptr        = NUM_Q - 1;
  logic             exp_valid  = 1'b0;
  sched_item_t      exp_item   = '0;
  logic [NUM_Q-1:0] en         = '1;
  int unsigned      gcount [NUM_Q];
  // DUT outputs sampled mid-cycle
  logic             out_valid_s;
  sched_item_t      out_item_s;
  logic [NUM_Q-1:0] push_ready_s;
  logic             awready_s;
  // Round-robin order check
  logic             seq_check  = 1'b0;
  int               last_qid   = NUM_Q - 1;
  // Bookkeeping
  int               err_egress = 0;
  int               err_flow   = 0;
  int               err_bus    = 0;
  int               refused    = 0;
  int               cycles     = 0;

  qsched_top dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .out_item   (out_item),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Next queue after last, wrapping; -1 if none eligible
  function automatic int next_queue(input int last, input logic [NUM_Q-1:0] elig);
    int idx;
    for (int i = 1; i <= NUM_Q; i++) begin
      idx = (last + i) % NUM_Q;
      if (elig[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  function automatic int model_backlog();
    int n;
    n = 0;
    for (int k = 0; k < NUM_Q; k++) begin
      n += mq[k].size();
    end
    return n;
  endfunction

  task automatic report_value(input int cat, input string name,
                              input logic [63:0] exp_v, input logic [63:0] got_v);
    $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp_v, got_v);
    case (cat)
      0:       err_egress++;
      1:       err_flow++;
      default: err_bus++;
    endcase
  endtask

  task automatic print_counts();
    $display("Errors: egress %0d, flow %0d, bus %0d", err_egress, err_flow, err_bus);
  endtask

  // Main loop waits land just past the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // -------------------------------------------------------------------------
  // Stimulus on the falling edge
  // -------------------------------------------------------------------------
  always @(negedge clk) begin
    for (int k = 0; k < NUM_Q; k++) begin
      rng           = xorshift32(rng);
      push_valid[k] = (push_mode == 1) || (push_mode == 2 && rng[31]);
      rng           = xorshift32(rng);
      push_data[k]  = rng;
    end
    rng = xorshift32(rng);
    // Random ready is high about three cycles in four
    out_ready = (ready_mode == 1) || (ready_mode == 2 && (rng[0] || rng[1]));
  end

  // Outputs only move on the rising edge
  always @(negedge clk) begin
    out_valid_s  = out_valid;
    out_item_s   = out_item;
    push_ready_s = push_ready;
    awready_s    = axil_rsp.awready;
  end

  // -------------------------------------------------------------------------
  // Reference model and comparator, one step per rising edge
  // -------------------------------------------------------------------------
  task automatic model_step();
    logic [NUM_Q-1:0] elig;
    logic [NUM_Q-1:0] room;
    int               pick;
    assert (out_valid_s == exp_valid) else report_value(0, "out_valid", exp_valid, out_valid_s);
    if (exp_valid && out_valid_s) begin
      assert (out_item_s == exp_item) else report_value(0, "out_item", exp_item, out_item_s);
    end
    // Space seen by the producers before this edge
    for (int k = 0; k < NUM_Q; k++) begin
      room[k] = mq[k].size() < FIFO_DEPTH;
      assert (push_ready_s[k] == room[k])
        else report_value(1, $sformatf("push_ready[%0d]", k), room[k], push_ready_s[k]);
    end
    // Egress transfer at this edge
    if (out_valid_s && out_ready && seq_check) begin
      assert (int'(out_item_s.qid) == (last_qid + 1) % NUM_Q)
        else report_value(0, "out_item.qid", (last_qid + 1) % NUM_Q, out_item_s.qid);
      last_qid = out_item_s.qid;
    end
    // Load uses entries visible before this edge
    for (int k = 0; k < NUM_Q; k++) begin
      elig[k] = en[k] && (mq[k].size() > 0);
    end
    pick = next_queue(ptr, elig);
    if ((!exp_valid || out_ready) && pick >= 0) begin
      exp_item.qid  = QID_W'(pick);
      exp_item.data = mq[pick].pop_front();
      exp_valid     = 1'b1;
      ptr           = pick;
      gcount[pick]++;
    end else if (out_ready) begin
      exp_valid = 1'b0;
    end
    // Register writes accepted at this edge, clear after increment
    if (awready_s && axil_req.awvalid && axil_req.wvalid) begin
      if (axil_req.awaddr == REG_CTRL) begin
        en = axil_req.wdata[NUM_Q-1:0];
      end
      for (int k = 0; k < NUM_Q; k++) begin
        if (axil_req.awaddr == REG_GCNT_BASE + 8'(4 * k)) begin
          gcount[k] = 0;
        end
      end
    end
    // Pushes become visible after this edge, a pop frees no space until then
    for (int k = 0; k < NUM_Q; k++) begin
      if (push_valid[k] && room[k]) begin
        mq[k].push_back(push_data[k]);
      end else if (push_valid[k]) begin
        refused++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (arst_n) begin
      model_step();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("Run stopped: no finish within %0d cycles", TIMEOUT);
      print_counts();
      $display("** FAIL **");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // AXI4-Lite master tasks
  // -------------------------------------------------------------------------
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    @(negedge clk);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    do @(negedge clk); while (!axil_rsp.awready);
    assert (axil_rsp.wready) else begin
      $display("Error at %0t: wready did not pulse together with awready", $time);
      err_bus++;
    end
    // Address and data taken on the coming edge
    @(negedge clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    while (!axil_rsp.bvalid) @(negedge clk);
    assert (axil_rsp.bresp == exp_resp) else report_value(2, "bresp", exp_resp, axil_rsp.bresp);
    @(negedge clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           input logic [1:0] exp_resp);
    @(negedge clk);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    do @(negedge clk); while (!axil_rsp.arready);
    @(negedge clk);
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    while (!axil_rsp.rvalid) @(negedge clk);
    data = axil_rsp.rdata;
    assert (axil_rsp.rresp == exp_resp) else report_value(2, "rresp", exp_resp, axil_rsp.rresp);
    @(negedge clk);
    axil_req.rready = 1'b0;
  endtask

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    int          refused_before;
    arst_n     = 1'b0;
    push_valid = '0;
    push_data  = '0;
    out_ready  = 1'b0;
    axil_req   = '0;
    for (int k = 0; k < NUM_Q; k++) begin
      gcount[k] = 0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Backlog every queue, then grants must rotate 0, 1, 2, 3
    wait_cycles(1);
    push_mode = 1;
    wait_cycles(12);
    ready_mode = 1;
    seq_check  = 1'b1;
    wait_cycles(40);
    seq_check = 1'b0;

    // Random pushes and random back-pressure
    push_mode  = 2;
    ready_mode = 2;
    wait_cycles(600);

    // Long stall fills the FIFOs
    refused_before = refused;
    ready_mode     = 0;
    wait_cycles(40);
    assert (refused > refused_before) else begin
      $display("Error at %0t: no push was refused during the egress stall", $time);
      err_flow++;
    end
    ready_mode = 2;
    wait_cycles(100);

    // Queue 2 disabled keeps its entries
    axil_write(REG_CTRL, 32'h0000_000B, RESP_OKAY);
    wait_cycles(60);
    axil_read(REG_STATUS, rd, RESP_OKAY);
    assert (rd[2] == 1'b1) else report_value(2, "status[2]", 1, rd[2]);
    axil_write(REG_CTRL, 32'h0000_000F, RESP_OKAY);
    wait_cycles(100);

    // Drain, then counters against the model
    push_mode  = 0;
    ready_mode = 1;
    while (model_backlog() != 0 || exp_valid) begin
      wait_cycles(1);
    end
    wait_cycles(4);
    axil_read(REG_STATUS, rd, RESP_OKAY);
    assert (rd == 32'h0) else report_value(2, "status", 0, rd);
    for (int k = 0; k < NUM_Q; k++) begin
      axil_read(REG_GCNT_BASE + 8'(4 * k), rd, RESP_OKAY);
      assert (rd == gcount[k]) else report_value(2, $sformatf("gcnt[%0d]", k), gcount[k], rd);
    end
    axil_write(REG_GCNT_BASE, 32'h0000_005A, RESP_OKAY);
    axil_read(REG_GCNT_BASE, rd, RESP_OKAY);
    assert (rd == 32'h0) else report_value(2, "gcnt[0]", 0, rd);

    // Unmapped, misaligned and read-only offsets
    axil_read(8'h08, rd, RESP_SLVERR);
    axil_read(8'h20, rd, RESP_SLVERR);
    axil_write(8'h08, 32'h0, RESP_SLVERR);
    axil_write(8'h15, 32'h0, RESP_SLVERR);
    axil_write(8'h20, 32'h0, RESP_SLVERR);
    axil_write(REG_STATUS, 32'h0, RESP_SLVERR);
    axil_read(REG_CTRL, rd, RESP_OKAY);
    assert (rd == 32'(en)) else report_value(2, "ctrl", en, rd);
    axil_read(REG_GCNT_BASE + 8'h4, rd, RESP_OKAY);
    assert (rd == gcount[1]) else report_value(2, "gcnt[1]", gcount[1], rd);

    wait_cycles(5);
    print_counts();
    if (err_egress + err_flow + err_bus == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
sched_pkg.sv
rr_arbiter.sv
fair_arb.sv
ingress_fifo.sv
egress_dispatch.sv
sched_csr.sv
qsched_top.sv
tb_qsched.sv
